//--- hw/rs_link_cfg.svh
// sizing constants for the erasure-tolerant symbol link
// include this wherever symbol, block or key widths are needed
`ifndef RS_LINK_CFG_SVH
`define RS_LINK_CFG_SVH

// one GF(16) symbol
`define RS_SYM_W     4
// data symbols per block, at x = 1..8
`define RS_K         8
// full codeword length, parity at x = 9..12
`define RS_N         12
`define RS_NPAR      4
// cipher key width, same as a symbol so the key adds mod 16
`define RS_KEY_W     4
// highest loss count that still counts as a good transfer
`define RS_MAX_LOST  4
// reduction polynomial x^4 + x + 1
`define RS_POLY      5'b10011

`endif

//--- hw/gf16_pkg.sv
// GF(16) field element type and arithmetic
// gf_mul and gf_inv synthesize to small xor networks
// lagrange_coef is meant for constant tables built at elaboration
`default_nettype none
`include "rs_link_cfg.svh"

package gf16_pkg;

    typedef logic [`RS_SYM_W-1:0] sym_t;

    // shift and add multiply, reduced by the field polynomial each step
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t              prod;
        logic [`RS_SYM_W:0] sh;
        prod = '0;
        sh   = {1'b0, a};
        for (int i = 0; i < `RS_SYM_W; i++) begin
            if (b[i]) begin
                prod = prod ^ sh[`RS_SYM_W-1:0];
            end
            sh = sh << 1;
            if (sh[`RS_SYM_W]) begin
                sh = sh ^ `RS_POLY;
            end
        end
        return prod;
    endfunction

    // a^14 = a^-1 in GF(16), zero maps to zero
    function automatic sym_t gf_inv(input sym_t a);
        sym_t a2;
        sym_t a4;
        sym_t a8;
        a2 = gf_mul(a, a);
        a4 = gf_mul(a2, a2);
        a8 = gf_mul(a4, a4);
        return gf_mul(gf_mul(a2, a4), a8);
    endfunction

    // basis polynomial of src_x over the point list xs, evaluated at dst_x
    // subtraction is xor in characteristic 2
    function automatic sym_t lagrange_coef(input sym_t src_x, input sym_t dst_x,
                                           input logic [`RS_K*`RS_SYM_W-1:0] xs);
        sym_t num;
        sym_t den;
        sym_t xm;
        num = sym_t'(1);
        den = sym_t'(1);
        for (int m = 0; m < `RS_K; m++) begin
            xm = xs[m*`RS_SYM_W +: `RS_SYM_W];
            if (xm != src_x) begin
                num = gf_mul(num, dst_x ^ xm);
                den = gf_mul(den, src_x ^ xm);
            end
        end
        return gf_mul(num, gf_inv(den));
    endfunction

endpackage

`default_nettype wire

//--- hw/link_pkg.sv
// block level types shared by the link stages
// element i of a block or codeword always carries the symbol at x = i+1
`default_nettype none
`include "rs_link_cfg.svh"

package link_pkg;

    // eight plaintext or enciphered data symbols
    typedef gf16_pkg::sym_t [`RS_K-1:0] data_block_t;

    // data in elements 0..7, parity in 8..11
    typedef gf16_pkg::sym_t [`RS_N-1:0] codeword_t;

    // one bit per codeword position, set means dropped
    typedef logic [`RS_N-1:0] loss_mask_t;

    // evaluation points for the lagrange evaluator
    // a four point target set sits in the low entries, the rest unused
    typedef gf16_pkg::sym_t [`RS_K-1:0] x_list_t;

    // losses per block, wide enough for all twelve positions
    typedef logic [3:0] lost_cnt_t;

endpackage

`default_nettype wire

//--- hw/lagrange_eval.sv
// combinational GF(16) lagrange evaluator
// given symbols at the eight SRC_X points, produces the interpolated
// values at the first four DST_X points
// point sets are parameters, so the coefficients fold to constants
`timescale 1ns/10ps
`default_nettype none
`include "rs_link_cfg.svh"

module lagrange_eval #(
    // entry 0 in the low nibble, default is x = 1..8
    parameter link_pkg::x_list_t SRC_X = 32'h8765_4321,
    // targets x = 9..12 by default
    parameter link_pkg::x_list_t DST_X = 32'h0000_cba9
) (
    input  gf16_pkg::sym_t [`RS_K-1:0]    src,
    output gf16_pkg::sym_t [`RS_NPAR-1:0] dst
);

    // coefficient times source for every target/source pair
    gf16_pkg::sym_t [`RS_NPAR-1:0][`RS_K-1:0] prod;

    for (genvar d = 0; d < `RS_NPAR; d++) begin : g_dst
        for (genvar s = 0; s < `RS_K; s++) begin : g_src
            // 32 constants in all, one per pair
            localparam gf16_pkg::sym_t COEF =
                gf16_pkg::lagrange_coef(SRC_X[s], DST_X[d], SRC_X);

            assign prod[d][s] = gf16_pkg::gf_mul(COEF, src[s]);
        end
    end

    // field addition is xor
    always_comb begin
        dst = '0;
        for (int d = 0; d < `RS_NPAR; d++) begin
            for (int s = 0; s < `RS_K; s++) begin
                dst[d] = dst[d] ^ prod[d][s];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rs_encoder.sv
// first link stage
// adds the key to each data symbol mod 16, evaluates four parity symbols
// at x = 9..12 over the enciphered block and registers the codeword
// the loss mask rides along so it stays aligned with its block
`timescale 1ns/10ps
`default_nettype none
`include "rs_link_cfg.svh"

module rs_encoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`RS_KEY_W-1:0]    key,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  link_pkg::data_block_t   in_data,
    input  link_pkg::loss_mask_t    in_loss_mask,
    output logic                    enc_valid,
    input  logic                    enc_ready,
    output link_pkg::codeword_t     enc_word,
    output link_pkg::loss_mask_t    enc_loss_mask
);

    link_pkg::data_block_t          cipher;
    gf16_pkg::sym_t [`RS_NPAR-1:0]  parity;

    // accept when the output register is free or drains this cycle
    assign in_ready = !enc_valid || enc_ready;

    // key add wraps at 4 bits, i.e. mod 16
    always_comb begin
        for (int i = 0; i < `RS_K; i++) begin
            cipher[i] = gf16_pkg::sym_t'(in_data[i] + key);
        end
    end

    // parity from data points 1..8 to targets 9..12
    lagrange_eval #(
        .SRC_X(32'h8765_4321),
        .DST_X(32'h0000_cba9)
    ) u_parity_eval (
        .src(cipher),
        .dst(parity)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enc_valid <= 1'b0;
        end else if (in_ready) begin
            enc_valid <= in_valid;
        end
    end

    // payload only loads on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            enc_word      <= {parity, cipher};
            enc_loss_mask <= in_loss_mask;
        end
    end

    // stalled codeword must not change under the channel
    a_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
        enc_valid && !enc_ready |=> $stable(enc_word) && enc_valid);

endmodule

`default_nettype wire

//--- hw/erasure_channel.sv
// lossy channel stage
// masked positions keep the last symbol delivered in that position,
// clear positions pass through, the block's losses are counted
// and a failure is flagged when more than RS_MAX_LOST are gone
`timescale 1ns/10ps
`default_nettype none
`include "rs_link_cfg.svh"

module erasure_channel (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enc_valid,
    output logic                    enc_ready,
    input  link_pkg::codeword_t     enc_word,
    input  link_pkg::loss_mask_t    enc_loss_mask,
    output logic                    ch_valid,
    input  logic                    ch_ready,
    output link_pkg::codeword_t     ch_word,
    output link_pkg::loss_mask_t    ch_lost,
    output link_pkg::lost_cnt_t     ch_lost_count,
    output logic                    ch_failed
);

    link_pkg::lost_cnt_t lost_cnt;

    assign enc_ready = !ch_valid || ch_ready;

    // population count of this block's mask
    always_comb begin
        lost_cnt = '0;
        for (int i = 0; i < `RS_N; i++) begin
            lost_cnt = lost_cnt + link_pkg::lost_cnt_t'(enc_loss_mask[i]);
        end
    end

    // ch_word is also the hold-last store
    // a lost position keeps the symbol it last delivered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ch_valid  <= 1'b0;
            ch_word   <= '0;
            ch_failed <= 1'b0;
        end else if (enc_ready) begin
            ch_valid <= enc_valid;
            if (enc_valid) begin
                ch_failed <= (lost_cnt > `RS_MAX_LOST);
                for (int i = 0; i < `RS_N; i++) begin
                    if (!enc_loss_mask[i]) begin
                        ch_word[i] <= enc_word[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enc_valid && enc_ready) begin
            ch_lost       <= enc_loss_mask;
            ch_lost_count <= lost_cnt;
        end
    end

    // loss count never exceeds the codeword length
    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        ch_valid |-> ch_lost_count <= `RS_N);

endmodule

`default_nettype wire

//--- hw/rs_recover.sv
// recovery stage
// rebuilds positions 5..8 from positions 1..4 and 9..12 by lagrange
// interpolation, flags a data error where an intact received symbol
// in 5..8 disagrees with its rebuilt value, then removes the key
// only this one point set is supported, other loss patterns are not repaired
`timescale 1ns/10ps
`default_nettype none
`include "rs_link_cfg.svh"

module rs_recover (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`RS_KEY_W-1:0]    key,
    input  logic                    ch_valid,
    output logic                    ch_ready,
    input  link_pkg::codeword_t     ch_word,
    input  link_pkg::loss_mask_t    ch_lost,
    input  link_pkg::lost_cnt_t     ch_lost_count,
    input  logic                    ch_failed,
    output logic                    out_valid,
    input  logic                    out_ready,
    output link_pkg::data_block_t   out_data,
    output link_pkg::lost_cnt_t     out_lost_count,
    output logic                    out_failed,
    output logic                    out_data_error
);

    gf16_pkg::sym_t [`RS_K-1:0]    known;
    gf16_pkg::sym_t [`RS_NPAR-1:0] rebuilt;
    link_pkg::data_block_t         plain;
    logic                          mismatch;

    assign ch_ready = !out_valid || out_ready;

    // sources at x = 1..4 then x = 9..12
    assign known = {ch_word[11:8], ch_word[3:0]};

    lagrange_eval #(
        .SRC_X(32'hcba9_4321),
        .DST_X(32'h0000_8765)
    ) u_rebuild_eval (
        .src(known),
        .dst(rebuilt)
    );

    always_comb begin
        mismatch = 1'b0;
        for (int i = 0; i < `RS_K; i++) begin
            if (i >= 4) begin
                // rebuilt symbol replaces the received one
                plain[i] = gf16_pkg::sym_t'(rebuilt[i-4] - key);
                // lost positions hold stale data and are not compared
                if (!ch_lost[i] && ch_word[i] != rebuilt[i-4]) begin
                    mismatch = 1'b1;
                end
            end else begin
                plain[i] = gf16_pkg::sym_t'(ch_word[i] - key);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid      <= 1'b0;
            out_failed     <= 1'b0;
            out_data_error <= 1'b0;
        end else if (ch_ready) begin
            out_valid <= ch_valid;
            if (ch_valid) begin
                out_failed     <= ch_failed;
                out_data_error <= mismatch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ch_valid && ch_ready) begin
            out_data       <= plain;
            out_lost_count <= ch_lost_count;
        end
    end

    // failure verdict from the channel agrees with the mask it carried
    a_fail_flag: assert property (@(posedge clk) disable iff (!rst_n)
        ch_valid && ch_ready && ($countones(ch_lost) > `RS_MAX_LOST) |=> out_failed);

endmodule

`default_nettype wire

//--- hw/rs_link_top.sv
// top of the symbol link, encoder then channel then recovery
// three register stages, one block per cycle at full throughput
// key must only change while the link is empty
`timescale 1ns/10ps
`default_nettype none
`include "rs_link_cfg.svh"

module rs_link_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`RS_KEY_W-1:0]    key,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  link_pkg::data_block_t   in_data,
    input  link_pkg::loss_mask_t    in_loss_mask,
    output logic                    out_valid,
    input  logic                    out_ready,
    output link_pkg::data_block_t   out_data,
    output link_pkg::lost_cnt_t     out_lost_count,
    output logic                    out_failed,
    output logic                    out_data_error
);

    // encoder to channel
    logic                 enc_valid;
    logic                 enc_ready;
    link_pkg::codeword_t  enc_word;
    link_pkg::loss_mask_t enc_loss_mask;

    // channel to recovery
    logic                 ch_valid;
    logic                 ch_ready;
    link_pkg::codeword_t  ch_word;
    link_pkg::loss_mask_t ch_lost;
    link_pkg::lost_cnt_t  ch_lost_count;
    logic                 ch_failed;

    rs_encoder u_rs_encoder (
        .clk(clk), .rst_n(rst_n), .key(key),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_data(in_data), .in_loss_mask(in_loss_mask),
        .enc_valid(enc_valid), .enc_ready(enc_ready),
        .enc_word(enc_word), .enc_loss_mask(enc_loss_mask)
    );

    erasure_channel u_erasure_channel (
        .clk(clk), .rst_n(rst_n),
        .enc_valid(enc_valid), .enc_ready(enc_ready),
        .enc_word(enc_word), .enc_loss_mask(enc_loss_mask),
        .ch_valid(ch_valid), .ch_ready(ch_ready), .ch_word(ch_word),
        .ch_lost(ch_lost), .ch_lost_count(ch_lost_count), .ch_failed(ch_failed)
    );

    rs_recover u_rs_recover (
        .clk(clk), .rst_n(rst_n), .key(key),
        .ch_valid(ch_valid), .ch_ready(ch_ready), .ch_word(ch_word),
        .ch_lost(ch_lost), .ch_lost_count(ch_lost_count), .ch_failed(ch_failed),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_lost_count(out_lost_count), .out_failed(out_failed),
        .out_data_error(out_data_error)
    );

endmodule

`default_nettype wire

//--- test/tb_rs_link.sv
// testbench for the erasure-tolerant symbol link
// reads blocks and their expected results from test/rs_link_stimulus.txt,
// pushes them through the DUT with random output stalls and input gaps,
// and checks every output transfer in order against the file
`timescale 1ns/10ps
`default_nettype none
`include "rs_link_cfg.svh"

module tb_rs_link;

    logic                   clk;
    logic                   rst_n;
    logic [`RS_KEY_W-1:0]   key;
    logic                   in_valid;
    logic                   in_ready;
    link_pkg::data_block_t  in_data;
    link_pkg::loss_mask_t   in_loss_mask;
    logic                   out_valid;
    logic                   out_ready;
    link_pkg::data_block_t  out_data;
    link_pkg::lost_cnt_t    out_lost_count;
    logic                   out_failed;
    logic                   out_data_error;

    // stimulus columns, indexed by block number
    logic [`RS_KEY_W-1:0]   key_q[$];
    link_pkg::data_block_t  data_q[$];
    link_pkg::loss_mask_t   mask_q[$];
    // expected results, popped as outputs transfer
    link_pkg::data_block_t  exp_data_q[$];
    link_pkg::lost_cnt_t    exp_cnt_q[$];
    logic                   exp_failed_q[$];
    logic                   exp_err_q[$];

    int                     num_vec;
    int                     sent;
    int                     received;
    int                     cycles;
    int                     cycle_limit;
    logic [15:0]            lfsr;

    rs_link_top u_rs_link_top (
        .clk(clk), .rst_n(rst_n), .key(key),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_data(in_data), .in_loss_mask(in_loss_mask),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_lost_count(out_lost_count), .out_failed(out_failed),
        .out_data_error(out_data_error)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // one pseudo random bit, lfsr steps once per bit
    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] k, d, m, ed, ec, ef, ee;
        fd = $fopen("test/rs_link_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the stimulus file test/rs_link_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines carry no block
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", k, d, m, ed, ec, ef, ee);
                    if (n != 7) begin
                        fail_run({"malformed stimulus line: ", line});
                    end else begin
                        key_q.push_back(k[`RS_KEY_W-1:0]);
                        data_q.push_back(d);
                        mask_q.push_back(m[`RS_N-1:0]);
                        exp_data_q.push_back(ed);
                        exp_cnt_q.push_back(ec[3:0]);
                        exp_failed_q.push_back(ef[0]);
                        exp_err_q.push_back(ee[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // compare one output transfer with the oldest expected result
    task automatic check_output();
        link_pkg::data_block_t ed;
        link_pkg::lost_cnt_t   ec;
        logic                  ef;
        logic                  ee;
        if (exp_data_q.size() == 0) begin
            fail_run("an output block arrived when no result was expected");
        end else begin
            ed = exp_data_q.pop_front();
            ec = exp_cnt_q.pop_front();
            ef = exp_failed_q.pop_front();
            ee = exp_err_q.pop_front();
            check_equal("out_data", 32'(out_data), 32'(ed));
            check_equal("out_lost_count", 32'(out_lost_count), 32'(ec));
            check_equal("out_failed", 32'(out_failed), 32'(ef));
            check_equal("out_data_error", 32'(out_data_error), 32'(ee));
            received++;
        end
    endtask

    task automatic drive_inputs(input logic fired);
        logic rdy;
        logic go;
        take_bit(rdy);
        out_ready = rdy;
        // a pending block stays on the bus until it transfers
        if (!in_valid || fired) begin
            // the key only changes once every block in flight is out
            if (sent >= num_vec || (key_q[sent] != key && received < sent)) begin
                in_valid = 1'b0;
            end else begin
                take_bit(go);
                key          = key_q[sent];
                in_data      = data_q[sent];
                in_loss_mask = mask_q[sent];
                in_valid     = go;
            end
        end
    endtask

    // handshakes are sampled at the falling edge, where they are settled
    task automatic run_cycle();
        logic in_fire;
        logic out_fire;
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            fail_run("timeout, the link stopped delivering results");
        end
        in_fire  = in_valid && in_ready;
        out_fire = out_valid && out_ready;
        if (out_fire) begin
            check_output();
        end
        if (in_fire) begin
            sent++;
        end
        @(posedge clk);
        #2;
        drive_inputs(in_fire);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        key          = '0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_loss_mask = '0;
        out_ready    = 1'b0;
        lfsr         = 16'd33;
        sent         = 0;
        received     = 0;
        cycles       = 0;
        read_stimulus();
        num_vec     = key_q.size();
        cycle_limit = 20 * num_vec + 100;
        if (num_vec == 0) begin
            fail_run("the stimulus file holds no blocks");
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        while (received < num_vec) begin
            run_cycle();
        end
        // extra cycles catch a duplicated block
        repeat (6) begin
            run_cycle();
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rs_link_stimulus.txt
# key data(x8..x1) loss_mask(bit0 = x1), then expected data lost_count failed data_error
# all fields hex, expected values worked in GF(16) with x^4+x+1
3 87654321 000 87654321 0 0 0
3 0f1e2d3c 000 0f1e2d3c 0 0 0
3 a5a5a5a5 0f0 a5a5a5a5 4 0 0
3 13579bdf 020 13579bdf 1 0 0
9 00000000 000 00000000 0 0 0
9 fedcba98 0a0 fedcba98 2 0 0
9 2468ace0 070 2468ace0 3 0 0
9 11223344 001 f6513340 1 0 1
9 55555555 021 b3325550 2 0 1
9 9abcdef0 001 9abcdef0 1 0 0
5 c0ffee42 000 c0ffee42 0 0 0
5 c0ffee42 fff c0ffee42 c 1 0
5 c0ffee42 0f1 c0ffee42 5 1 0
5 c0ffee42 e3c c0ffee42 7 1 0
f deadbeef 000 deadbeef 0 0 0
f 76543210 0c0 76543210 2 0 0

//--- files.f
+incdir+hw
hw/gf16_pkg.sv
hw/link_pkg.sv
hw/lagrange_eval.sv
hw/rs_encoder.sv
hw/erasure_channel.sv
hw/rs_recover.sv
hw/rs_link_top.sv
test/tb_rs_link.sv

//--- run_sim.sh
#!/bin/sh
# build the link testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rs_link \
    -f files.f -o sim_rs_link > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_rs_link > sim.log 2>&1
status=$?
cat sim.log
if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
